// ==== multiport_mem_top.f ====
+incdir+hw
hw/mem_pkg.sv
hw/phy_pkg.sv
hw/req_intake.sv
hw/row_align.sv
hw/read_return.sv
hw/multiport_mem_top.sv
tests/tb_clock_gen.sv
tests/tb_sram_model.sv
tests/tb_multiport_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_multiport_mem
FILELIST  ?= multiport_mem_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o sim
	-./$(OBJ_DIR)/sim | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_multiport_mem.sv ====
`include "mem_cfg.svh"

module tb_multiport_mem;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;
  import phy_pkg::*;

  localparam int NP             = `MEM_NUMRUPT;
  localparam int LANE_W         = $bits(lane_t);
  localparam int LADDR_W        = $bits(laddr_t);
  localparam int STIM_CYCLES    = 400;
  localparam int TIMEOUT_CYCLES = 8 * STIM_CYCLES + 8 + `MEM_NUMSROW;
  localparam int RD_SEEN        = `MEM_SRAM_DELAY + 2;  // rd_vld set 2 edges on, seen one later

  typedef struct packed {
    int unsigned due;
    logic        serr;
    logic        fwrd;
    padr_t       padr;
    word_t       data;
  } exp_t;

  logic              clk;
  logic              rst_n;
  logic              wr_valid;
  laddr_t            wr_addr;
  word_t             wr_data;
  logic              ready;
  rport_t            rd_req;
  laddr_t [NP-1:0]   rd_addr;
  rport_t            rd_vld;
  word_t  [NP-1:0]   rd_dout;
  rport_t            rd_fwrd;
  rport_t            rd_serr;
  padr_t  [NP-1:0]   rd_padr;
  logic   [NP-1:0]   t1_write;
  srow_t  [NP-1:0]   t1_wr_addr;
  lmask_t [NP-1:0]   t1_bw;
  prow_t  [NP-1:0]   t1_din;
  logic   [NP-1:0]   t1_read;
  srow_t  [NP-1:0]   t1_rd_addr;
  prow_t  [NP-1:0]   t1_dout;

  word_t       ref_mem   [`MEM_NUMADDR];
  word_t       flip_mask [NP][`MEM_NUMADDR];  // Bits flipped in each copy
  exp_t        exp_q     [NP][$];
  logic [31:0] seed;
  int unsigned cycle;
  string       test_name;

  tb_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

  multiport_mem_top u_multiport_mem_top (.*);

  for (genvar i = 0; i < NP; i++) begin : g_sram
    tb_sram_model u_sram (
      .clk     (clk),
      .write   (t1_write[i]),
      .wr_addr (t1_wr_addr[i]),
      .bw      (t1_bw[i]),
      .din     (t1_din[i]),
      .read    (t1_read[i]),
      .rd_addr (t1_rd_addr[i]),
      .dout    (t1_dout[i])
    );
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic padr_t split_padr(input laddr_t a, input logic f);
    srow_t row;
    lane_t lane;
    row  = a[LADDR_W-1:LANE_W];  // High bits pick the row
    lane = a[LANE_W-1:0];
    return {f, row, lane};
  endfunction

  task automatic stop_run(input string why);
    $display("Testbench failed");
    $fatal(1, "%s in test %s", why, test_name);
  endtask

  task automatic flag_mismatch(input string what, input int p, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    $display("Testbench failed");
    $display("ERR %s port %0d %s expected %h actual %h", test_name, p, what, exp_v, act_v);
    $fatal(1);
  endtask

  task automatic drive_cycle(input logic wv, input laddr_t wa, input word_t wd,
                             input rport_t rq, input laddr_t [NP-1:0] ra);
    @(posedge clk);
    wr_valid <= wv;
    wr_addr  <= wa;
    wr_data  <= wd;
    rd_req   <= rq;
    rd_addr  <= ra;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, '0, '0);
  endtask

  function automatic laddr_t [NP-1:0] rand_addrs();
    laddr_t [NP-1:0] ra;
    for (int p = 0; p < NP; p++) begin
      ra[p] = laddr_t'(next_rand() >> 16);
    end
    return ra;
  endfunction

  // Flips one data bit of a stored word in copy 0 only
  task automatic corrupt_word(input laddr_t a, input int pos);
    flip_mask[0][a] = flip_mask[0][a] ^ (word_t'(1) << pos);
    g_sram[0].u_sram.flip_bit(int'(a[LADDR_W-1:LANE_W]), int'(a[LANE_W-1:0]) * `MEM_LANEW + pos);
  endtask

  always @(posedge clk) begin : check
    exp_t   e;
    laddr_t a;
    cycle = cycle + 1;
    if (cycle > TIMEOUT_CYCLES) stop_run("Run timed out before all reads returned");
    if (rst_n) begin
      for (int p = 0; p < NP; p++) begin
        if (rd_vld[p]) begin
          if (exp_q[p].size() == 0) stop_run("rd_vld came without a pending read");
          e = exp_q[p].pop_front();
          assert (cycle == e.due) else flag_mismatch("latency", p, e.due, cycle);
          assert (rd_dout[p] == e.data) else flag_mismatch("rd_dout", p, e.data, rd_dout[p]);
          assert (rd_fwrd[p] == e.fwrd) else flag_mismatch("rd_fwrd", p, e.fwrd, rd_fwrd[p]);
          assert (rd_serr[p] == e.serr) else flag_mismatch("rd_serr", p, e.serr, rd_serr[p]);
          assert (rd_padr[p] == e.padr) else flag_mismatch("rd_padr", p, e.padr, rd_padr[p]);
        end else if (exp_q[p].size() != 0 && exp_q[p][0].due <= cycle) begin
          stop_run("Read result never came back");
        end
      end
      if (ready) begin
        for (int p = 0; p < NP; p++) begin
          if (rd_req[p]) begin
            a      = rd_addr[p];
            e.due  = cycle + RD_SEEN;
            e.fwrd = wr_valid && (wr_addr == a);
            e.data = e.fwrd ? wr_data : (ref_mem[a] ^ flip_mask[p][a]);
            e.serr = !e.fwrd && (flip_mask[p][a] != '0);
            e.padr = split_padr(a, e.fwrd);
            exp_q[p].push_back(e);
          end
        end
        if (wr_valid) begin
          ref_mem[wr_addr] = wr_data;
          for (int p = 0; p < NP; p++) begin
            flip_mask[p][wr_addr] = '0;
          end
        end
      end
    end
  end

  a_quiet_until_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    !ready |-> (rd_vld == '0)
  ) else stop_run("rd_vld rose before ready");

  a_fwrd_clean: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rd_fwrd & rd_serr) == '0
  ) else stop_run("Forwarded read reported a parity error");

  initial begin
    int     n;
    laddr_t a;
    word_t  d;
    seed      = 32'h9674e6b1;
    cycle     = 0;
    test_name = "init";
    rst_n     = 1'b0;
    wr_valid  = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    rd_req    = '0;
    rd_addr   = '0;
    for (int i = 0; i < `MEM_NUMADDR; i++) begin
      ref_mem[i] = '0;
      for (int p = 0; p < NP; p++) begin
        flip_mask[p][i] = '0;
      end
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    n = 0;
    while (!ready) begin
      drive_cycle(1'b0, '0, '0, rport_t'(next_rand() >> 20), rand_addrs());  // Must be dropped
      n++;
      if (n > 4 * `MEM_NUMSROW) stop_run("ready never rose after reset");
    end
    // ready is seen one edge after the edge that sets it
    assert (n == `MEM_NUMSROW + 1) else flag_mismatch("ready delay", 0, `MEM_NUMSROW + 1, n);

    test_name = "unwritten";
    repeat (8) drive_cycle(1'b0, '0, '0, '1, rand_addrs());

    test_name = "write_read";
    repeat (40) drive_cycle(1'b1, laddr_t'(next_rand() >> 10), word_t'(next_rand() >> 8), '0, '0);
    repeat (40) drive_cycle(1'b0, '0, '0, rport_t'(next_rand() >> 12), rand_addrs());

    test_name = "back_to_back";
    repeat (200) begin
      drive_cycle(1'(next_rand() >> 31), laddr_t'(next_rand() >> 10), word_t'(next_rand() >> 8),
                  '1, rand_addrs());
    end

    test_name = "forward";
    idle_cycles(3);
    a = 6'h2a;
    d = word_t'(next_rand() >> 4);
    drive_cycle(1'b1, a, d, '1, {NP{a}});
    drive_cycle(1'b0, '0, '0, '1, {NP{a}});
    idle_cycles(3);

    test_name = "parity";
    a = 6'h13;
    drive_cycle(1'b1, a, 16'h5a3c, '0, '0);
    idle_cycles(3);
    corrupt_word(a, 5);
    idle_cycles(3);
    drive_cycle(1'b0, '0, '0, '1, {NP{a}});
    drive_cycle(1'b1, a, 16'h0ff0, '1, {NP{a}});  // Old row in copy 0 still has the bad bit
    idle_cycles(2);

    test_name = "drain";
    n = 0;
    while (exp_q[0].size() != 0 || exp_q[NP-1].size() != 0) begin
      idle_cycles(1);
      n++;
      if (n > 20) stop_run("Reads still pending after drain");
    end
    idle_cycles(4);
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== tests/tb_sram_model.sv ====
`include "mem_cfg.svh"

module tb_sram_model (
  input  logic            clk,
  input  logic            write,
  input  phy_pkg::srow_t  wr_addr,
  input  phy_pkg::lmask_t bw,
  input  phy_pkg::prow_t  din,
  input  logic            read,
  input  phy_pkg::srow_t  rd_addr,
  output phy_pkg::prow_t  dout
);
  timeunit 1ns;
  timeprecision 1ps;
  import phy_pkg::*;

  prow_t mem     [`MEM_NUMSROW];
  prow_t rd_pipe [`MEM_SRAM_DELAY];
  int    flip_req;
  int    flip_ack;
  int    flip_row;
  int    flip_pos;

  // Junk content that the init sweep has to clear
  initial begin
    for (int i = 0; i < `MEM_NUMSROW; i++) begin
      mem[i] = {`MEM_NUMWRDS{17'(i * 2713 + 17'h0a5c3)}};
    end
    flip_req = 0;
    flip_ack = 0;
  end

  always @(posedge clk) begin
    if (write) begin
      mem[wr_addr] <= (mem[wr_addr] & ~bw) | (din & bw);
    end
    if (flip_req != flip_ack) begin
      mem[flip_row][flip_pos] <= ~mem[flip_row][flip_pos];  // Lands on the next edge
      flip_ack <= flip_req;
    end
    if (read) begin
      rd_pipe[0] <= mem[rd_addr];  // Old row when read and write share the edge
    end
    for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[`MEM_SRAM_DELAY-1];

  task flip_bit(input int row, input int pos);
    flip_row = row;
    flip_pos = pos;
    flip_req = flip_req + 1;
  endtask

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== hw/multiport_mem_top.sv ====
`include "mem_cfg.svh"

module multiport_mem_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wr_valid,
  input  mem_pkg::laddr_t                      wr_addr,
  input  mem_pkg::word_t                       wr_data,
  output logic                                 ready,
  input  mem_pkg::rport_t                      rd_req,
  input  mem_pkg::laddr_t [`MEM_NUMRUPT-1:0]   rd_addr,
  output mem_pkg::rport_t                      rd_vld,
  output mem_pkg::word_t  [`MEM_NUMRUPT-1:0]   rd_dout,
  output mem_pkg::rport_t                      rd_fwrd,
  output mem_pkg::rport_t                      rd_serr,
  output phy_pkg::padr_t  [`MEM_NUMRUPT-1:0]   rd_padr,
  output logic            [`MEM_NUMRUPT-1:0]   t1_write,
  output phy_pkg::srow_t  [`MEM_NUMRUPT-1:0]   t1_wr_addr,
  output phy_pkg::lmask_t [`MEM_NUMRUPT-1:0]   t1_bw,
  output phy_pkg::prow_t  [`MEM_NUMRUPT-1:0]   t1_din,
  output logic            [`MEM_NUMRUPT-1:0]   t1_read,
  output phy_pkg::srow_t  [`MEM_NUMRUPT-1:0]   t1_rd_addr,
  input  phy_pkg::prow_t  [`MEM_NUMRUPT-1:0]   t1_dout
);
  import mem_pkg::*;
  import phy_pkg::*;

  cmd_op_t                    cmd_op;
  laddr_t                     cmd_addr;
  word_t                      cmd_data;
  rport_t                     cmd_read;
  laddr_t [`MEM_NUMRUPT-1:0]  cmd_raddr;

  logic   [`MEM_NUMRUPT-1:0]  ctx_vld;
  lane_t  [`MEM_NUMRUPT-1:0]  ctx_lane;
  srow_t  [`MEM_NUMRUPT-1:0]  ctx_srow;
  logic   [`MEM_NUMRUPT-1:0]  ctx_fwrd;
  word_t  [`MEM_NUMRUPT-1:0]  ctx_fdata;

  req_intake u_req_intake (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_valid  (wr_valid),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .ready     (ready),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .cmd_read  (cmd_read),
    .cmd_raddr (cmd_raddr)
  );

  // Every copy takes the same write, reads only for its own port
  for (genvar i = 0; i < `MEM_NUMRUPT; i++) begin : g_copy
    row_align u_row_align (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_op     (cmd_op),
      .cmd_addr   (cmd_addr),
      .cmd_data   (cmd_data),
      .cmd_read   (cmd_read[i]),
      .cmd_raddr  (cmd_raddr[i]),
      .t1_write   (t1_write[i]),
      .t1_wr_addr (t1_wr_addr[i]),
      .t1_bw      (t1_bw[i]),
      .t1_din     (t1_din[i]),
      .t1_read    (t1_read[i]),
      .t1_rd_addr (t1_rd_addr[i]),
      .ctx_vld    (ctx_vld[i]),
      .ctx_lane   (ctx_lane[i]),
      .ctx_srow   (ctx_srow[i]),
      .ctx_fwrd   (ctx_fwrd[i]),
      .ctx_fdata  (ctx_fdata[i])
    );
  end

  for (genvar i = 0; i < `MEM_NUMRUPT; i++) begin : g_port
    read_return u_read_return (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctx_vld   (ctx_vld[i]),
      .ctx_lane  (ctx_lane[i]),
      .ctx_srow  (ctx_srow[i]),
      .ctx_fwrd  (ctx_fwrd[i]),
      .ctx_fdata (ctx_fdata[i]),
      .t1_dout   (t1_dout[i]),
      .rd_vld    (rd_vld[i]),
      .rd_dout   (rd_dout[i]),
      .rd_fwrd   (rd_fwrd[i]),
      .rd_serr   (rd_serr[i]),
      .rd_padr   (rd_padr[i])
    );
  end

endmodule

// ==== hw/read_return.sv ====
`include "mem_cfg.svh"

module read_return (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ctx_vld,
  input  phy_pkg::lane_t   ctx_lane,
  input  phy_pkg::srow_t   ctx_srow,
  input  logic             ctx_fwrd,
  input  mem_pkg::word_t   ctx_fdata,
  input  phy_pkg::prow_t   t1_dout,
  output logic             rd_vld,
  output mem_pkg::word_t   rd_dout,
  output logic             rd_fwrd,
  output logic             rd_serr,
  output phy_pkg::padr_t   rd_padr
);
  import mem_pkg::*;

  logic [`MEM_LANEW-1:0] lane_bits;
  word_t                 lane_data;
  logic                  par_err;

  assign lane_bits = t1_dout[int'(ctx_lane) * `MEM_LANEW +: `MEM_LANEW];
  assign lane_data = lane_bits[`MEM_WIDTH-1:0];
  assign par_err   = ^lane_bits;  // Odd count of ones in the lane

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld  <= 1'b0;
      rd_fwrd <= 1'b0;
      rd_serr <= 1'b0;
    end else begin
      rd_vld  <= ctx_vld;
      rd_fwrd <= ctx_vld && ctx_fwrd;
      rd_serr <= ctx_vld && !ctx_fwrd && par_err;  // Forwarded data skips the check
    end
  end

  always_ff @(posedge clk) begin
    rd_dout <= ctx_fwrd ? ctx_fdata : lane_data;
    rd_padr <= {ctx_fwrd, ctx_srow, ctx_lane};
  end

  a_serr_with_vld: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_serr |-> rd_vld
  ) else $error("rd_serr raised without rd_vld");

endmodule

// ==== hw/row_align.sv ====
`include "mem_cfg.svh"

module row_align (
  input  logic              clk,
  input  logic              rst_n,
  input  mem_pkg::cmd_op_t  cmd_op,
  input  mem_pkg::laddr_t   cmd_addr,
  input  mem_pkg::word_t    cmd_data,
  input  logic              cmd_read,
  input  mem_pkg::laddr_t   cmd_raddr,
  output logic              t1_write,
  output phy_pkg::srow_t    t1_wr_addr,
  output phy_pkg::lmask_t   t1_bw,
  output phy_pkg::prow_t    t1_din,
  output logic              t1_read,
  output phy_pkg::srow_t    t1_rd_addr,
  output logic              ctx_vld,
  output phy_pkg::lane_t    ctx_lane,
  output phy_pkg::srow_t    ctx_srow,
  output logic              ctx_fwrd,
  output mem_pkg::word_t    ctx_fdata
);
  import mem_pkg::*;
  import phy_pkg::*;

  localparam int LANE_W  = $bits(lane_t);
  localparam int LADDR_W = $bits(laddr_t);
  localparam int DEPTH   = `MEM_SRAM_DELAY;

  lane_t wr_lane;
  logic  wr_par;
  logic  fwrd;

  logic [DEPTH-1:0] vld_pipe;
  lane_t            lane_pipe  [DEPTH];
  srow_t            srow_pipe  [DEPTH];
  logic             fwrd_pipe  [DEPTH];
  word_t            fdata_pipe [DEPTH];

  assign wr_lane    = cmd_addr[LANE_W-1:0];
  assign t1_wr_addr = cmd_addr[LADDR_W-1:LANE_W];
  assign wr_par     = ^cmd_data;  // Even parity over the lane

  always_comb begin
    t1_write = 1'b0;
    t1_bw    = '0;
    t1_din   = '0;
    case (cmd_op)
      OP_WRITE: begin
        t1_write = 1'b1;
        t1_bw    = lmask_t'({`MEM_LANEW{1'b1}}) << (int'(wr_lane) * `MEM_LANEW);
        t1_din   = prow_t'({wr_par, cmd_data}) << (int'(wr_lane) * `MEM_LANEW);
      end
      OP_CLEAR: begin
        t1_write = 1'b1;
        t1_bw    = '1;
      end
      default: ;
    endcase
  end

  assign t1_read    = cmd_read;
  assign t1_rd_addr = cmd_raddr[LADDR_W-1:LANE_W];

  // SRAM returns the old row when read and write hit the same edge
  assign fwrd = cmd_read && (cmd_op == OP_WRITE) && (cmd_addr == cmd_raddr);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= cmd_read;
      for (int i = 1; i < DEPTH; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    lane_pipe[0]  <= cmd_raddr[LANE_W-1:0];
    srow_pipe[0]  <= cmd_raddr[LADDR_W-1:LANE_W];
    fwrd_pipe[0]  <= fwrd;
    fdata_pipe[0] <= cmd_data;
    for (int i = 1; i < DEPTH; i++) begin
      lane_pipe[i]  <= lane_pipe[i-1];
      srow_pipe[i]  <= srow_pipe[i-1];
      fwrd_pipe[i]  <= fwrd_pipe[i-1];
      fdata_pipe[i] <= fdata_pipe[i-1];
    end
  end

  assign ctx_vld   = vld_pipe[DEPTH-1];  // Lines up with t1_dout
  assign ctx_lane  = lane_pipe[DEPTH-1];
  assign ctx_srow  = srow_pipe[DEPTH-1];
  assign ctx_fwrd  = fwrd_pipe[DEPTH-1];
  assign ctx_fdata = fdata_pipe[DEPTH-1];

  a_bw_needs_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    (|t1_bw) |-> t1_write
  ) else $error("byte mask active without a write");

endmodule

// ==== hw/req_intake.sv ====
`include "mem_cfg.svh"

module req_intake (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wr_valid,
  input  mem_pkg::laddr_t                      wr_addr,
  input  mem_pkg::word_t                       wr_data,
  input  mem_pkg::rport_t                      rd_req,
  input  mem_pkg::laddr_t [`MEM_NUMRUPT-1:0]   rd_addr,
  output logic                                 ready,
  output mem_pkg::cmd_op_t                     cmd_op,
  output mem_pkg::laddr_t                      cmd_addr,
  output mem_pkg::word_t                       cmd_data,
  output mem_pkg::rport_t                      cmd_read,
  output mem_pkg::laddr_t [`MEM_NUMRUPT-1:0]   cmd_raddr
);
  import mem_pkg::*;
  import phy_pkg::*;

  localparam srow_t LAST_ROW = srow_t'(`MEM_NUMSROW - 1);

  intake_state_t state;
  srow_t         row_cnt;
  logic          wr_acc;

  assign wr_acc = wr_valid && ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= INIT_CLEAR;
      row_cnt  <= '0;
      ready    <= 1'b0;
      cmd_op   <= OP_NONE;
      cmd_read <= '0;
    end else begin
      cmd_read <= rd_req & {`MEM_NUMRUPT{ready}};  // Strobes outside ready are dropped
      case (state)
        INIT_CLEAR: begin
          cmd_op  <= OP_CLEAR;
          row_cnt <= row_cnt + 1'b1;
          if (row_cnt == LAST_ROW) begin
            state <= RUN;
            ready <= 1'b1;  // Last clear row goes out with ready
          end
        end
        default: begin
          cmd_op <= wr_acc ? OP_WRITE : OP_NONE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    cmd_raddr <= rd_addr;
    if (state == INIT_CLEAR) begin
      cmd_addr <= {row_cnt, lane_t'(0)};  // Row of the sweep
    end else if (wr_acc) begin
      cmd_addr <= wr_addr;
      cmd_data <= wr_data;
    end
  end

  a_ready_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == RUN) |=> (ready && state == RUN)
  ) else $error("ready fell after the init sweep");

endmodule

// ==== hw/phy_pkg.sv ====
`include "mem_cfg.svh"

package phy_pkg;

  typedef logic [$clog2(`MEM_NUMSROW)-1:0] srow_t;  // Physical row address

  typedef logic [$clog2(`MEM_NUMWRDS)-1:0] lane_t;  // Word lane inside a row

  // Lane n sits at bits [n*LANEW +: LANEW], parity on top of each lane
  typedef logic [`MEM_NUMWRDS*`MEM_LANEW-1:0] prow_t;

  typedef logic [`MEM_NUMWRDS*`MEM_LANEW-1:0] lmask_t;  // Per-bit write enable

  // {fwrd, srow, lane}
  typedef logic [$bits(srow_t)+$bits(lane_t):0] padr_t;

endpackage

// ==== hw/mem_pkg.sv ====
`include "mem_cfg.svh"

package mem_pkg;

  typedef logic [`MEM_WIDTH-1:0] word_t;

  typedef logic [$clog2(`MEM_NUMADDR)-1:0] laddr_t;  // {row, lane}

  typedef logic [`MEM_NUMRUPT-1:0] rport_t;  // One bit per read port

  typedef enum logic {
    INIT_CLEAR,  // Sweeping zero rows into every copy
    RUN
  } intake_state_t;

  // What row_align writes this cycle
  typedef enum logic [1:0] {
    OP_NONE,
    OP_WRITE,  // Single lane, data plus parity
    OP_CLEAR   // Whole row of zeros
  } cmd_op_t;

endpackage

// ==== hw/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Logical word size in bits
`define MEM_WIDTH 16

// Read ports, one SRAM copy each
`define MEM_NUMRUPT 2

`define MEM_NUMADDR 64

// Logical words packed into one physical row
`define MEM_NUMWRDS 4

`define MEM_NUMSROW 16

// Cycles from SRAM read strobe to t1_dout
`define MEM_SRAM_DELAY 1

// Data plus one even parity bit
`define MEM_LANEW (`MEM_WIDTH + 1)

`endif
